/* run_sim.sh */
#!/usr/bin/env bash
# build and run the divider testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module int_div_iterative_tb -Mdir obj_dir > "$build_log" 2>&1
if [ $? -ne 0 ]; then
  cat "$build_log"
  echo "build failed"
  exit 1
fi

./obj_dir/Vint_div_iterative_tb > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "ERRORS FOUND" "$sim_log"; then
  echo "simulation reported failures"
  exit 1
fi

exit 0

/* src/div_operand_stage.sv */
// ---------------------------------------------------------------------
// one-entry input buffer, operands leave as magnitudes with sign flags
// accepts a new request in the same cycle the held one is taken
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module div_operand_stage (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_val,
  output logic                       req_rdy,
  input  int_div_pkg::div_req_t      req,
  output logic                       op_val,
  input  logic                       op_rdy,
  output int_div_pkg::div_operands_t op
);
  import int_div_pkg::*;

  logic          full;
  logic          is_signed;
  logic          a_neg;
  logic          b_neg;
  div_operands_t op_next;

  // --------------------------------------------------------------------
  // magnitude conversion
  // --------------------------------------------------------------------

  // sign bits only count in signed mode
  assign is_signed = (req.fn == div_fn_signed);
  assign a_neg     = is_signed & req.a[data_w-1];
  assign b_neg     = is_signed & req.b[data_w-1];

  always_comb begin
    // two's complement negate when the operand is negative
    op_next.mag_a    = a_neg ? (~req.a + 1'b1) : req.a;
    op_next.mag_b    = b_neg ? (~req.b + 1'b1) : req.b;
    // quotient negative when exactly one operand is negative
    op_next.neg_quo  = a_neg ^ b_neg;
    // remainder follows the dividend
    op_next.neg_rem  = a_neg;
    op_next.div_zero = (req.b == '0);
  end

  // --------------------------------------------------------------------
  // one-entry buffer
  // --------------------------------------------------------------------

  // free slot, or the held item leaves this cycle
  assign req_rdy = !full || op_rdy;
  assign op_val  = full;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (req_val && req_rdy) begin
      full <= 1'b1;
    end else if (op_rdy) begin
      full <= 1'b0;
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (req_val && req_rdy) begin
      op <= op_next;
    end
  end

  // held operands must not move while the core is busy
  op_hold_a : assert property (@(posedge clk) disable iff (reset)
    op_val && !op_rdy |=> op_val && $stable(op));

endmodule

/* src/div_restoring_core.sv */
// ---------------------------------------------------------------------
// restoring shift-subtract divider on unsigned magnitudes
// fixed 32 steps per division, no early exit for small operands
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module div_restoring_core (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       op_val,
  output logic                       op_rdy,
  input  int_div_pkg::div_operands_t op,
  output logic                       raw_val,
  input  logic                       raw_rdy,
  output int_div_pkg::div_raw_t      raw
);
  import int_div_pkg::*;

  div_state_e          state;
  logic [cnt_w-1:0]    cnt;
  logic                last_step;

  // upper part is the partial remainder, lower part collects quotient bits
  logic [2*data_w:0]   rq;
  // divisor aligned with the upper part of rq
  logic [2*data_w:0]   dv;
  logic [2*data_w:0]   rq_shift;
  logic [2*data_w:0]   rq_diff;
  logic [2*data_w:0]   rq_next;

  // flags carried through to the result stage
  logic                neg_quo;
  logic                neg_rem;
  logic                div_zero;
  logic [data_w-1:0]   orig_a;

  assign op_rdy    = (state == st_idle);
  assign raw_val   = (state == st_done);
  assign last_step = (cnt == cnt_w'(iter_count - 1));

  // --------------------------------------------------------------------
  // one restoring step
  // --------------------------------------------------------------------

  always_comb begin
    rq_shift = {rq[2*data_w-1:0], 1'b0};
    rq_diff  = rq_shift - dv;
    // negative difference means restore, quotient bit stays zero
    if (rq_diff[2*data_w]) begin
      rq_next = rq_shift;
    end else begin
      rq_next = {rq_diff[2*data_w:1], 1'b1};
    end
  end

  // --------------------------------------------------------------------
  // control FSM
  // --------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      unique case (state)
        st_idle: begin
          if (op_val) begin
            state <= st_calc;
            cnt   <= '0;
          end
        end
        st_calc: begin
          // wraps back to zero after the last step
          cnt <= cnt + 1'b1;
          if (last_step) begin
            state <= st_done;
          end
        end
        st_done: begin
          if (raw_rdy) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // datapath registers
  always_ff @(posedge clk) begin
    if (op_val && op_rdy) begin
      rq       <= {{(data_w+1){1'b0}}, op.mag_a};
      dv       <= {1'b0, op.mag_b, {data_w{1'b0}}};
      neg_quo  <= op.neg_quo;
      neg_rem  <= op.neg_rem;
      div_zero <= op.div_zero;
      // neg_rem is only set for a negative signed dividend, so this rebuilds it
      orig_a   <= op.neg_rem ? (~op.mag_a + 1'b1) : op.mag_a;
    end else if (state == st_calc) begin
      rq <= rq_next;
    end
  end

  // divide by zero needs no special case here, every trial subtract passes
  always_comb begin
    raw.quo      = rq[data_w-1:0];
    raw.rem      = rq[2*data_w-1:data_w];
    raw.neg_quo  = neg_quo;
    raw.neg_rem  = neg_rem;
    raw.div_zero = div_zero;
    raw.orig_a   = orig_a;
  end

  // counter rests at zero whenever no division is running
  cnt_idle_a : assert property (@(posedge clk) disable iff (reset)
    state != st_calc |-> cnt == '0);

  // a result appears exactly iter_count steps after the core left idle
  raw_after_calc_a : assert property (@(posedge clk) disable iff (reset)
    $rose(raw_val) |-> $past(state == st_calc, iter_count) &&
                       $past(state == st_idle, iter_count + 1));

endmodule

/* src/div_result_stage.sv */
// ---------------------------------------------------------------------
// one-entry output register with sign and divide-by-zero fixups
// divide by zero gives all ones and the dividend in both modes
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module div_result_stage (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  raw_val,
  output logic                  raw_rdy,
  input  int_div_pkg::div_raw_t raw,
  output logic                  resp_val,
  input  logic                  resp_rdy,
  output int_div_pkg::div_resp_t resp
);
  import int_div_pkg::*;

  logic      full;
  div_resp_t resp_next;

  // --------------------------------------------------------------------
  // result fixup
  // --------------------------------------------------------------------

  always_comb begin
    if (raw.div_zero) begin
      resp_next.quo = '1;
      resp_next.rem = raw.orig_a;
    end else begin
      // most negative / -1 lands on 32'h8000_0000 through the negate
      resp_next.quo = raw.neg_quo ? (~raw.quo + 1'b1) : raw.quo;
      resp_next.rem = raw.neg_rem ? (~raw.rem + 1'b1) : raw.rem;
    end
  end

  // --------------------------------------------------------------------
  // output register
  // --------------------------------------------------------------------

  // empty, or the held response is taken this cycle
  assign raw_rdy  = !full || resp_rdy;
  assign resp_val = full;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (raw_val && raw_rdy) begin
      full <= 1'b1;
    end else if (resp_rdy) begin
      full <= 1'b0;
    end
  end

  // response payload
  always_ff @(posedge clk) begin
    if (raw_val && raw_rdy) begin
      resp <= resp_next;
    end
  end

  // stalled response holds its value until taken
  resp_hold_a : assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp));

endmodule

/* src/int_div_iterative.sv */
// ---------------------------------------------------------------------
// iterative divider top, three stages with one item each
// about 34 cycles per division, responses in request order
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module int_div_iterative (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_val,
  output logic                   req_rdy,
  input  int_div_pkg::div_req_t  req,
  output logic                   resp_val,
  input  logic                   resp_rdy,
  output int_div_pkg::div_resp_t resp
);
  import int_div_pkg::*;

  // operand stage to core
  logic          op_val;
  logic          op_rdy;
  div_operands_t op;

  // core to result stage
  logic          raw_val;
  logic          raw_rdy;
  div_raw_t      raw;

  div_operand_stage operand_stage_i (
    .clk     (clk),
    .reset   (reset),
    .req_val (req_val),
    .req_rdy (req_rdy),
    .req     (req),
    .op_val  (op_val),
    .op_rdy  (op_rdy),
    .op      (op)
  );

  div_restoring_core restoring_core_i (
    .clk     (clk),
    .reset   (reset),
    .op_val  (op_val),
    .op_rdy  (op_rdy),
    .op      (op),
    .raw_val (raw_val),
    .raw_rdy (raw_rdy),
    .raw     (raw)
  );

  div_result_stage result_stage_i (
    .clk      (clk),
    .reset    (reset),
    .raw_val  (raw_val),
    .raw_rdy  (raw_rdy),
    .raw      (raw),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp     (resp)
  );

endmodule

/* src/int_div_pkg.sv */
// ---------------------------------------------------------------------
// shared types for the iterative 32-bit divider
// responses pack the remainder in the upper half, quotient in the lower
// ---------------------------------------------------------------------

package int_div_pkg;

  // operand and result width
  localparam int data_w = 32;
  // one restoring step per quotient bit
  localparam int iter_count = 32;
  // iteration counter wraps to zero after the last step
  localparam int cnt_w = 5;

  typedef enum logic {
    div_fn_unsigned = 1'b0,
    div_fn_signed   = 1'b1
  } div_fn_e;

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } div_state_e;

  // request as seen on the external port
  typedef struct packed {
    div_fn_e             fn;
    logic [data_w-1:0]   a;
    logic [data_w-1:0]   b;
  } div_req_t;

  // unsigned operands plus the sign fixups for the result stage
  typedef struct packed {
    logic [data_w-1:0]   mag_a;
    logic [data_w-1:0]   mag_b;
    logic                neg_quo;
    logic                neg_rem;
    logic                div_zero;
  } div_operands_t;

  // unsigned core result, flags and original dividend ride along
  typedef struct packed {
    logic [data_w-1:0]   quo;
    logic [data_w-1:0]   rem;
    logic                neg_quo;
    logic                neg_rem;
    logic                div_zero;
    logic [data_w-1:0]   orig_a;
  } div_raw_t;

  typedef struct packed {
    logic [data_w-1:0]   rem;
    logic [data_w-1:0]   quo;
  } div_resp_t;

endpackage

/* tb/int_div_iterative_tb.sv */
// ---------------------------------------------------------------------
// testbench for the iterative divider, checks run as assertions
// a timeout skips the remaining requests and ends the run
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module int_div_iterative_tb;
  import int_div_pkg::*;

  localparam int req_limit   = 400;
  localparam int drain_limit = 4000;

  logic      clk;
  logic      reset;
  logic      req_val;
  logic      req_rdy;
  div_req_t  req;
  logic      resp_val;
  logic      resp_rdy;
  div_resp_t resp;

  // expected responses in request order
  div_resp_t exp_q[$];
  div_resp_t exp_head;
  int        exp_cnt;
  int        errors;
  int        checked;
  bit        timed_out;
  bit        bp_mode;
  bit        saw_stall;

  int_div_iterative int_div_iterative_i (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req      (req),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp     (resp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // expected response straight from the sign and divide-by-zero rules
  function automatic div_resp_t expected_resp(div_fn_e fn, logic [31:0] a, logic [31:0] b);
    logic [31:0] mag_a;
    logic [31:0] mag_b;
    logic [31:0] q;
    logic [31:0] r;
    logic        a_neg;
    logic        b_neg;
    div_resp_t   e;
    a_neg = (fn == div_fn_signed) && a[31];
    b_neg = (fn == div_fn_signed) && b[31];
    mag_a = a_neg ? -a : a;
    mag_b = b_neg ? -b : b;
    if (b == '0) begin
      e.quo = '1;
      e.rem = a;
    end else begin
      q     = mag_a / mag_b;
      r     = mag_a % mag_b;
      e.quo = (a_neg ^ b_neg) ? -q : q;
      e.rem = a_neg ? -r : r;
    end
    return e;
  endfunction

  // --------------------------------------------------------------------
  // scoreboard queue, updated on the handshake edges
  // --------------------------------------------------------------------

  always @(posedge clk) begin
    if (req_val && !req_rdy) begin
      saw_stall = 1'b1;
    end
    if (req_val && req_rdy) begin
      exp_q.push_back(expected_resp(req.fn, req.a, req.b));
    end
    if (resp_val && resp_rdy && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
      checked++;
    end
    exp_cnt  = exp_q.size();
    exp_head = (exp_q.size() != 0) ? exp_q[0] : '0;
  end

  // --------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------

  reset_resp_val_a : assert property (@(posedge clk) $fell(reset) |-> !resp_val)
    else begin
      $display("Fail %0t resp_val exp 0 got %b", $time, $sampled(resp_val));
      errors++;
    end

  reset_req_rdy_a : assert property (@(posedge clk) $fell(reset) |-> req_rdy)
    else begin
      $display("Fail %0t req_rdy exp 1 got %b", $time, $sampled(req_rdy));
      errors++;
    end

  resp_expected_a : assert property (@(posedge clk) disable iff (reset)
    resp_val && resp_rdy |-> exp_cnt != 0)
    else begin
      $display("%0t: response arrived with no request outstanding", $time);
      errors++;
    end

  quo_match_a : assert property (@(posedge clk) disable iff (reset)
    resp_val && resp_rdy |-> resp.quo == exp_head.quo)
    else begin
      $display("Fail %0t resp.quo exp %h got %h", $time,
               $sampled(exp_head.quo), $sampled(resp.quo));
      errors++;
    end

  rem_match_a : assert property (@(posedge clk) disable iff (reset)
    resp_val && resp_rdy |-> resp.rem == exp_head.rem)
    else begin
      $display("Fail %0t resp.rem exp %h got %h", $time,
               $sampled(exp_head.rem), $sampled(resp.rem));
      errors++;
    end

  // a stalled response must hold still
  resp_stall_a : assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> $stable(resp))
    else begin
      $display("%0t: resp changed while stalled", $time);
      errors++;
    end

  // --------------------------------------------------------------------
  // stimulus helpers, called 10 ns after a rising edge
  // --------------------------------------------------------------------

  task automatic end_run();
    $display("responses checked %0d, errors %0d", checked, errors);
    if (errors == 0 && !timed_out) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  task automatic send_req(input div_fn_e fn, input logic [31:0] a, input logic [31:0] b);
    int waited;
    waited = 0;
    if (!timed_out) begin
      req_val = 1'b1;
      req.fn  = fn;
      req.a   = a;
      req.b   = b;
      // req_rdy does not depend on req_val, so it is settled here
      while (!req_rdy && waited < req_limit) begin
        @(posedge clk);
        #10;
        waited++;
      end
      if (!req_rdy) begin
        $display("timeout: request not accepted within %0d cycles", req_limit);
        timed_out = 1'b1;
        req_val   = 1'b0;
      end else begin
        @(posedge clk);
        #10;
        req_val = 1'b0;
      end
    end
  endtask

  task automatic drain_queue();
    int waited;
    waited = 0;
    if (!timed_out) begin
      while (exp_cnt != 0 && waited < drain_limit) begin
        @(posedge clk);
        #10;
        waited++;
      end
      if (exp_cnt != 0) begin
        $display("timeout: %0d responses still missing", exp_cnt);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s done, %0d responses checked, %0d errors", name, checked, errors);
  endtask

  // resp_rdy held high unless the back-pressure test runs
  initial begin
    logic [31:0] rnd;
    resp_rdy = 1'b1;
    forever begin
      @(posedge clk);
      #10;
      rnd      = $urandom;
      resp_rdy = bp_mode ? rnd[0] : 1'b1;
    end
  end

  // --------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    div_fn_e     fn;
    void'($urandom(32'h923fff6e));
    reset     = 1'b1;
    req_val   = 1'b0;
    req       = '0;
    errors    = 0;
    checked   = 0;
    exp_cnt   = 0;
    exp_head  = '0;
    timed_out = 1'b0;
    bp_mode   = 1'b0;
    saw_stall = 1'b0;
    repeat (2) @(posedge clk);
    #10;
    reset = 1'b0;
    @(posedge clk);
    #10;
    report_test("reset_state");

    // unsigned, some divisors larger than the dividend
    send_req(div_fn_unsigned, 32'd100, 32'd7);
    send_req(div_fn_unsigned, 32'd5, 32'd7);
    send_req(div_fn_unsigned, 32'h0000_1234, 32'hffff_0000);
    send_req(div_fn_unsigned, 32'hffff_ffff, 32'd1);
    for (int i = 0; i < 16; i++) begin
      a = $urandom;
      b = $urandom >> ($urandom % 32);
      if (i % 4 == 0) begin
        a = a >> 16;
      end
      send_req(div_fn_unsigned, a, b);
    end
    drain_queue();
    report_test("unsigned");

    // signed, all sign mixes plus the overflow corner
    send_req(div_fn_signed, -32'sd7, 32'sd2);
    send_req(div_fn_signed, 32'sd7, -32'sd2);
    send_req(div_fn_signed, -32'sd7, -32'sd2);
    send_req(div_fn_signed, 32'h8000_0000, 32'hffff_ffff);
    for (int i = 0; i < 16; i++) begin
      a = $urandom;
      b = $urandom >> ($urandom % 32);
      if (i % 2 == 0) begin
        b = -b;
      end
      send_req(div_fn_signed, a, b);
    end
    drain_queue();
    report_test("signed");

    send_req(div_fn_unsigned, 32'd123, 32'd0);
    send_req(div_fn_unsigned, 32'd0, 32'd0);
    send_req(div_fn_signed, -32'sd5, 32'd0);
    send_req(div_fn_signed, 32'h8000_0000, 32'd0);
    drain_queue();
    report_test("divide_by_zero");

    // back to back requests with random stalls on the response side
    bp_mode   = 1'b1;
    saw_stall = 1'b0;
    for (int i = 0; i < 16; i++) begin
      fn = div_fn_e'($urandom % 2);
      a  = $urandom;
      b  = $urandom >> ($urandom % 32);
      send_req(fn, a, b);
    end
    drain_queue();
    bp_mode = 1'b0;
    stall_seen_a : assert (saw_stall)
      else begin
        $display("req_rdy never fell during back-to-back requests");
        errors++;
      end
    queue_empty_a : assert (exp_q.size() == 0)
      else begin
        $display("%0d expected responses never arrived", exp_q.size());
        errors++;
      end
    report_test("backpressure_order");

    end_run();
  end

endmodule

/* vlog.f */
src/int_div_pkg.sv
src/div_operand_stage.sv
src/div_restoring_core.sv
src/div_result_stage.sv
src/int_div_iterative.sv
tb/int_div_iterative_tb.sv
